// ==== bench/dsp_backend_tb.sv ====
`timescale 1ns/100ps
`include "dsp_config.svh"

module dsp_backend_tb;
	import dsp_types_pkg::*;
	import dsp_cfg_pkg::*;

	localparam int CW          = `CHANNEL_WIDTH;
	localparam int UNITY_WORDS = 32;
	localparam int TAP_WORDS   = 24;
	localparam int WIDE_WORDS  = 16;
	localparam int SLICE_WORDS = 16;
	localparam int MLSD_WORDS  = 20;
	localparam int SETTLE      = 4;
	localparam int FLUSH       = 5;
	// data and idle words over all tests and their eight configuration groups.
	localparam int N_WORDS = UNITY_WORDS + TAP_WORDS + 4 + WIDE_WORDS + 3 * SLICE_WORDS
		+ 2 * (MLSD_WORDS + 3) + 8 * (SETTLE + FLUSH);

	logic                   clk;
	logic                   rstb;
	code_t                  codes_i [CW];
	logic                   wb_cyc_i;
	logic                   wb_stb_i;
	logic                   wb_we_i;
	logic [`CFG_ADDR_W-1:0] wb_adr_i;
	logic [31:0]            wb_dat_i;
	logic [31:0]            wb_dat_o;
	logic                   wb_ack_o;
	code_t                  estimated_o [CW];
	logic                   checked_bits_o [CW];

	integer seed;
	bit     track_word;
	int     sym_hist [$];
	bit     chk_hist [$];
	int     w_m [3];
	int     shift_m;
	int     thresh_m;
	int     h0_m;
	int     h1_m;
	int     n_checks;
	int     word_errors;
	int     code_errors;
	int     bit_errors;
	int     other_errors;
	code_t  zero_w [CW];

	dsp_backend dsp_backend_i (
		.clk            (clk),
		.rstb           (rstb),
		.codes_i        (codes_i),
		.wb_cyc_i       (wb_cyc_i),
		.wb_stb_i       (wb_stb_i),
		.wb_we_i        (wb_we_i),
		.wb_adr_i       (wb_adr_i),
		.wb_dat_i       (wb_dat_i),
		.wb_dat_o       (wb_dat_o),
		.wb_ack_o       (wb_ack_o),
		.estimated_o    (estimated_o),
		.checked_bits_o (checked_bits_o)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// every word the DUT samples with lane 0 first.
	always @(posedge clk) begin
		if (rstb) begin
			for (int l = 0; l < CW; l++)
				sym_hist.push_back(int'(codes_i[l]));
			chk_hist.push_back(track_word);
		end
	end

	// ******************************
	// reference model
	// ******************************

	function automatic int sym_at(input int n);
		if (n < 0)
			return 0;
		return sym_hist[n];
	endfunction

	function automatic int ffe_model(input int n);
		int acc;
		acc = w_m[0] * sym_at(n) + w_m[1] * sym_at(n - 1) + w_m[2] * sym_at(n - 2);
		acc = acc >>> shift_m;
		if (acc > 127)
			return 127;
		if (acc < -128)
			return -128;
		return acc;
	endfunction

	function automatic bit slice_model(input int n);
		if (n < 0)
			return 1'b0;
		return ffe_model(n) > thresh_m;
	endfunction

	function automatic bit mlsd_model(input int n);
		int x;
		int isi;
		int d0;
		int d1;
		x   = sym_at(n);
		isi = slice_model(n - 1) ? h1_m : -h1_m;
		d0  = x - (isi - h0_m);
		d1  = x - (isi + h0_m);
		d0  = (d0 < 0) ? -d0 : d0;
		d1  = (d1 < 0) ? -d1 : d1;
		if (d1 < d0)
			return 1'b1;
		if (d0 < d1)
			return 1'b0;
		return slice_model(n);
	endfunction

	// ******************************
	// compare tasks
	// ******************************

	task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
		n_checks++;
		if (got !== exp) begin
			word_errors++;
			$display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_codes(input code_t got [CW], input code_t exp [CW], input string what);
		bit diff;
		diff = 1'b0;
		for (int l = 0; l < CW; l++) begin
			if (got[l] !== exp[l])
				diff = 1'b1;
		end
		n_checks++;
		if (diff) begin
			code_errors++;
			$display("FAIL %0t: %s is %p, expected %p", $time, what, got, exp);
		end
	endtask

	task automatic check_bits(input logic got [CW], input logic exp [CW], input string what);
		bit diff;
		diff = 1'b0;
		for (int l = 0; l < CW; l++) begin
			if (got[l] !== exp[l])
				diff = 1'b1;
		end
		n_checks++;
		if (diff) begin
			bit_errors++;
			$display("FAIL %0t: %s is %p, expected %p", $time, what, got, exp);
		end
	endtask

	// outputs after the last edge belong to the words two and four back.
	task automatic compare_outputs();
		int    len;
		code_t exp_codes [CW];
		logic  exp_bits [CW];
		len = chk_hist.size();
		if (len >= 2 && chk_hist[len-2]) begin
			for (int l = 0; l < CW; l++)
				exp_codes[l] = code_t'(ffe_model((len - 2) * CW + l));
			check_codes(estimated_o, exp_codes, "estimated_o");
		end
		if (len >= 4 && chk_hist[len-4]) begin
			for (int l = 0; l < CW; l++)
				exp_bits[l] = mlsd_model((len - 4) * CW + l);
			check_bits(checked_bits_o, exp_bits, "checked_bits_o");
		end
	endtask

	// ******************************
	// stimulus
	// ******************************

	task automatic send_word(input code_t w [CW], input bit chk);
		@(posedge clk);
		#1;
		compare_outputs();
		codes_i    = w;
		track_word = chk;
	endtask

	task automatic send_random(input int count);
		code_t w [CW];
		repeat (count) begin
			for (int l = 0; l < CW; l++)
				w[l] = code_t'($random(seed));
			send_word(w, 1'b1);
		end
	endtask

	// codes near the four expected levels of h0 = 40 and h1 = 10.
	task automatic send_near(input int count);
		code_t w [CW];
		int    base;
		repeat (count) begin
			for (int l = 0; l < CW; l++) begin
				case ($random(seed) & 3)
					0:       base = 50;
					1:       base = 30;
					2:       base = -30;
					default: base = -50;
				endcase
				w[l] = code_t'(base + $random(seed) % 4);
			end
			send_word(w, 1'b1);
		end
	endtask

	task automatic flush_pipeline();
		repeat (FLUSH)
			send_word(zero_w, 1'b0);
	endtask

	task automatic wait_ack();
		int n;
		n = 0;
		do begin
			@(posedge clk);
			#1;
			n++;
		end while (!wb_ack_o && n < 16);
		if (!wb_ack_o) begin
			other_errors++;
			$display("no Wishbone ack within %0d cycles at %0t", n, $time);
		end else
			check_word(32'(n), 32'd1, "Wishbone ack latency in cycles");
	endtask

	task automatic wb_write(input logic [`CFG_ADDR_W-1:0] adr, input logic [31:0] dat);
		@(posedge clk);
		#1;
		wb_cyc_i = 1'b1;
		wb_stb_i = 1'b1;
		wb_we_i  = 1'b1;
		wb_adr_i = adr;
		wb_dat_i = dat;
		wait_ack();
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i  = 1'b0;
		@(posedge clk);
		#1;
		check_word(32'(wb_ack_o), 32'h0, "wb_ack_o one cycle after a write");
	endtask

	task automatic wb_read(input logic [`CFG_ADDR_W-1:0] adr, output logic [31:0] dat);
		@(posedge clk);
		#1;
		wb_cyc_i = 1'b1;
		wb_stb_i = 1'b1;
		wb_we_i  = 1'b0;
		wb_adr_i = adr;
		wait_ack();
		dat      = wb_dat_o;
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		@(posedge clk);
		#1;
		check_word(32'(wb_ack_o), 32'h0, "wb_ack_o one cycle after a read");
	endtask

	task automatic set_config(input int w0, input int w1, input int w2, input int shift,
		input int thresh, input int h0, input int h1);
		wb_write(CFG_TAPS, {5'd0, 3'(shift), 8'(w2), 8'(w1), 8'(w0)});
		wb_write(CFG_SLICE, {8'd0, 8'(h1), 8'(h0), 8'(thresh)});
		w_m      = '{w0, w1, w2};
		shift_m  = shift;
		thresh_m = thresh;
		h0_m     = h0;
		h1_m     = h1;
		repeat (SETTLE)
			send_word(zero_w, 1'b0);
	endtask

	// ******************************
	// tests
	// ******************************

	task automatic reset_and_registers();
		logic [31:0] rd;
		code_t       zero_c [CW];
		logic        zero_b [CW];
		zero_c = '{default: '0};
		zero_b = '{default: 1'b0};
		check_codes(estimated_o, zero_c, "estimated_o after reset");
		check_bits(checked_bits_o, zero_b, "checked_bits_o after reset");
		check_word(wb_dat_o, 32'h0, "wb_dat_o after reset");
		check_word(32'(wb_ack_o), 32'h0, "wb_ack_o after reset");
		wb_read(CFG_TAPS, rd);
		check_word(rd, 32'h0, "taps register after reset");
		wb_read(CFG_SLICE, rd);
		check_word(rd, 32'h0, "slice register after reset");
		wb_write(CFG_TAPS, 32'h05a3_7f81);
		wb_write(CFG_SLICE, 32'hc40a_28f6);
		wb_read(CFG_TAPS, rd);
		check_word(rd, 32'h05a3_7f81, "taps register read back");
		wb_read(CFG_SLICE, rd);
		check_word(rd, 32'hc40a_28f6, "slice register read back");
		wb_read(2'd2, rd);
		check_word(rd, 32'h0, "unmapped address 2");
		wb_write(2'd3, 32'hffff_ffff);
		wb_read(2'd3, rd);
		check_word(rd, 32'h0, "unmapped address 3 after a write");
		wb_read(CFG_TAPS, rd);
		check_word(rd, 32'h05a3_7f81, "taps register after unmapped write");
		wb_read(CFG_SLICE, rd);
		check_word(rd, 32'hc40a_28f6, "slice register after unmapped write");
	endtask

	task automatic unity_tap_test();
		set_config(1, 0, 0, 0, 0, 0, 0);
		send_random(UNITY_WORDS);
		flush_pipeline();
	endtask

	task automatic multi_tap_test();
		code_t hi [CW];
		code_t lo [CW];
		hi = '{default: 127};
		lo = '{default: -128};
		set_config(40, -25, 12, 2, 0, 0, 0);
		send_word(hi, 1'b1);
		send_word(hi, 1'b1);
		send_word(lo, 1'b1);
		send_word(lo, 1'b1);
		send_random(TAP_WORDS);
		flush_pipeline();
		set_config(127, -128, 127, 7, 0, 0, 0);
		send_random(WIDE_WORDS);
		flush_pipeline();
	endtask

	task automatic slicer_pass_test(input int thresh);
		set_config(2, -1, 0, 1, thresh, 0, 0);
		send_random(SLICE_WORDS);
		flush_pipeline();
	endtask

	// ties sit at +-10 and lane 0 ties depend on the bit carried from lane 3.
	task automatic mlsd_test(input int thresh);
		code_t w_a [CW];
		code_t w_b [CW];
		code_t w_c [CW];
		w_a = '{50, 30, -30, 50};
		w_b = '{10, -10, 30, -50};
		w_c = '{-10, 50, 10, 30};
		set_config(1, 0, 0, 0, thresh, 40, 10);
		send_word(w_a, 1'b1);
		send_word(w_b, 1'b1);
		send_word(w_c, 1'b1);
		send_near(MLSD_WORDS);
		flush_pipeline();
	endtask

	initial begin
		#((N_WORDS + 200) * 8);
		$display("timeout: run still busy after %0d ns", (N_WORDS + 200) * 8);
		$display("checks %0d, errors: word %0d, codes %0d, bits %0d, other %0d",
			n_checks, word_errors, code_errors, bit_errors, other_errors + 1);
		$display("** FAIL **");
		$finish;
	end

	initial begin
		seed         = 91168;
		rstb         = 1'b0;
		codes_i      = '{default: '0};
		zero_w       = '{default: '0};
		wb_cyc_i     = 1'b0;
		wb_stb_i     = 1'b0;
		wb_we_i      = 1'b0;
		wb_adr_i     = '0;
		wb_dat_i     = '0;
		track_word   = 1'b0;
		n_checks     = 0;
		word_errors  = 0;
		code_errors  = 0;
		bit_errors   = 0;
		other_errors = 0;
		repeat (3) @(posedge clk);
		#1;
		rstb = 1'b1;
		reset_and_registers();
		unity_tap_test();
		multi_tap_test();
		slicer_pass_test(0);
		slicer_pass_test(50);
		slicer_pass_test(-40);
		mlsd_test(35);
		mlsd_test(-20);
		$display("checks %0d, errors: word %0d, codes %0d, bits %0d, other %0d",
			n_checks, word_errors, code_errors, bit_errors, other_errors);
		if (word_errors + code_errors + bit_errors + other_errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

// ==== build.f ====
+incdir+include
hw/dsp_types_pkg.sv
hw/dsp_cfg_pkg.sv
hw/dsp_cfg_regs.sv
hw/ffe_slicer.sv
hw/code_history.sv
hw/mlsd_checker.sv
hw/dsp_backend.sv
bench/dsp_backend_tb.sv

// ==== hw/code_history.sv ====
`timescale 1ns/100ps
`include "dsp_config.svh"

module code_history (
	input  logic                 clk,
	input  logic                 rstb,
	input  dsp_types_pkg::code_t codes_i [`CHANNEL_WIDTH],
	output dsp_types_pkg::code_t aligned_o [`CHANNEL_WIDTH]
);
	import dsp_types_pkg::*;

	localparam int CW    = `CHANNEL_WIDTH;
	localparam int DEPTH = `CODE_ALIGN_DEPTH;

	// entry 0 is loaded on the sampling edge.
	code_t hist_q [DEPTH][CW];

	// ******************************
	// raw code delay line
	// ******************************

	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			for (int d = 0; d < DEPTH; d++) begin
				for (int l = 0; l < CW; l++)
					hist_q[d][l] <= '0;
			end
		end else begin
			hist_q[0] <= codes_i;
			for (int d = 1; d < DEPTH; d++)
				hist_q[d] <= hist_q[d-1];
		end
	end

	// the last stage lands with the slicer bits of the same word.
	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb)
			aligned_o <= '{default: '0};
		else
			aligned_o <= hist_q[DEPTH-1];
	end

endmodule

// ==== hw/dsp_backend.sv ====
`timescale 1ns/100ps
`include "dsp_config.svh"

module dsp_backend (
	input  logic                   clk,
	input  logic                   rstb,
	input  dsp_types_pkg::code_t   codes_i [`CHANNEL_WIDTH],
	input  logic                   wb_cyc_i,
	input  logic                   wb_stb_i,
	input  logic                   wb_we_i,
	input  logic [`CFG_ADDR_W-1:0] wb_adr_i,
	input  logic [`WB_DATA_W-1:0]  wb_dat_i,
	output logic [`WB_DATA_W-1:0]  wb_dat_o,
	output logic                   wb_ack_o,
	output dsp_types_pkg::code_t   estimated_o [`CHANNEL_WIDTH],
	output logic                   checked_bits_o [`CHANNEL_WIDTH]
);
	import dsp_types_pkg::*;

	weight_t             weights [`FFE_LENGTH];
	logic [`SHIFT_W-1:0] ffe_shift;
	code_t               thresh;
	est_t                h0;
	est_t                h1;
	logic                bits [`CHANNEL_WIDTH];
	code_t               aligned [`CHANNEL_WIDTH];

	dsp_cfg_regs dsp_cfg_regs_i (
		.clk         (clk),
		.rstb        (rstb),
		.wb_cyc_i    (wb_cyc_i),
		.wb_stb_i    (wb_stb_i),
		.wb_we_i     (wb_we_i),
		.wb_adr_i    (wb_adr_i),
		.wb_dat_i    (wb_dat_i),
		.wb_dat_o    (wb_dat_o),
		.wb_ack_o    (wb_ack_o),
		.weights_o   (weights),
		.ffe_shift_o (ffe_shift),
		.thresh_o    (thresh),
		.h0_o        (h0),
		.h1_o        (h1)
	);

	// equalized path.
	ffe_slicer ffe_slicer_i (
		.clk         (clk),
		.rstb        (rstb),
		.codes_i     (codes_i),
		.weights_i   (weights),
		.ffe_shift_i (ffe_shift),
		.thresh_i    (thresh),
		.estimated_o (estimated_o),
		.bits_o      (bits)
	);

	// raw path.
	code_history code_history_i (
		.clk       (clk),
		.rstb      (rstb),
		.codes_i   (codes_i),
		.aligned_o (aligned)
	);

	mlsd_checker mlsd_checker_i (
		.clk            (clk),
		.rstb           (rstb),
		.bits_i         (bits),
		.codes_i        (aligned),
		.h0_i           (h0),
		.h1_i           (h1),
		.checked_bits_o (checked_bits_o)
	);

endmodule

// ==== hw/dsp_cfg_pkg.sv ====
`include "dsp_config.svh"

package dsp_cfg_pkg;

	import dsp_types_pkg::*;

	// ******************************
	// register map
	// ******************************

	// word addresses, 2 and 3 are unmapped.
	typedef enum logic [`CFG_ADDR_W-1:0] {
		CFG_TAPS  = 0,
		CFG_SLICE = 1
	} cfg_addr_e;

	// ffe weights in the low three bytes, shift above them.
	typedef struct packed {
		logic [`WB_DATA_W-3*`WEIGHT_W-`SHIFT_W-1:0] rsvd;
		logic [`SHIFT_W-1:0]                        ffe_shift;
		weight_t                                    w2;
		weight_t                                    w1;
		weight_t                                    w0;
	} cfg_taps_t;

	// slicer threshold and the two channel estimate taps.
	typedef struct packed {
		logic [`WB_DATA_W-2*`WEIGHT_W-`CODE_W-1:0] rsvd;
		est_t                                      h1;
		est_t                                      h0;
		code_t                                     thresh;
	} cfg_slice_t;

	// one bus word, seen as raw data or as either register.
	typedef union packed {
		logic [`WB_DATA_W-1:0] raw;
		cfg_taps_t             taps;
		cfg_slice_t            slice;
	} cfg_word_u;

endpackage

// ==== hw/dsp_cfg_regs.sv ====
`timescale 1ns/100ps
`include "dsp_config.svh"

module dsp_cfg_regs (
	input  logic                   clk,
	input  logic                   rstb,
	input  logic                   wb_cyc_i,
	input  logic                   wb_stb_i,
	input  logic                   wb_we_i,
	input  logic [`CFG_ADDR_W-1:0] wb_adr_i,
	input  logic [`WB_DATA_W-1:0]  wb_dat_i,
	output logic [`WB_DATA_W-1:0]  wb_dat_o,
	output logic                   wb_ack_o,
	output dsp_types_pkg::weight_t weights_o [`FFE_LENGTH],
	output logic [`SHIFT_W-1:0]    ffe_shift_o,
	output dsp_types_pkg::code_t   thresh_o,
	output dsp_types_pkg::est_t    h0_o,
	output dsp_types_pkg::est_t    h1_o
);
	import dsp_cfg_pkg::*;

	cfg_word_u             taps_q;
	cfg_word_u             slice_q;
	cfg_addr_e             addr;
	logic                  req;
	logic [`WB_DATA_W-1:0] rd_data;

	// new request seen while ack is low.
	assign req  = wb_cyc_i & wb_stb_i & ~wb_ack_o;
	assign addr = cfg_addr_e'(wb_adr_i);

	always_comb begin
		case (addr)
			CFG_TAPS:  rd_data = taps_q.raw;
			CFG_SLICE: rd_data = slice_q.raw;
			default:   rd_data = '0;
		endcase
	end

	// ******************************
	// bus cycle and storage
	// ******************************

	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			wb_ack_o <= 1'b0;
			wb_dat_o <= '0;
			taps_q   <= '0;
			slice_q  <= '0;
		end else begin
			wb_ack_o <= req;
			if (req && wb_we_i) begin
				// full word writes, unmapped words drop the data.
				case (addr)
					CFG_TAPS:  taps_q.raw <= wb_dat_i;
					CFG_SLICE: slice_q.raw <= wb_dat_i;
					default: ;
				endcase
			end
			if (req && !wb_we_i)
				wb_dat_o <= rd_data;
		end
	end

	// fan out through the two register views.
	assign weights_o[0] = taps_q.taps.w0;
	assign weights_o[1] = taps_q.taps.w1;
	assign weights_o[2] = taps_q.taps.w2;
	assign ffe_shift_o  = taps_q.taps.ffe_shift;
	assign thresh_o     = slice_q.slice.thresh;
	assign h0_o         = slice_q.slice.h0;
	assign h1_o         = slice_q.slice.h1;

	// ******************************
	// protocol checks
	// ******************************

	// ack only answers a live strobe.
	ack_after_request: assert property (@(posedge clk) disable iff (!rstb)
		$rose(wb_ack_o) |-> $past(wb_cyc_i && wb_stb_i));

	// single cycle ack.
	ack_single_cycle: assert property (@(posedge clk) disable iff (!rstb)
		wb_ack_o |=> !wb_ack_o);

endmodule

// ==== hw/dsp_types_pkg.sv ====
`include "dsp_config.svh"

package dsp_types_pkg;

	// ******************************
	// datapath words
	// ******************************

	// raw adc code and saturated ffe output.
	typedef logic signed [`CODE_W-1:0] code_t;

	// ffe tap weight.
	typedef logic signed [`WEIGHT_W-1:0] weight_t;

	// channel estimate tap for the mlsd check.
	typedef logic signed [`WEIGHT_W-1:0] est_t;

	// sum of three code by weight products.
	typedef logic signed [`ACC_W-1:0] acc_t;

	// room for a code minus two estimate taps.
	localparam int ERR_W = `WEIGHT_W + 3;
	typedef logic signed [ERR_W-1:0] err_t;

	localparam int CODE_MAX = 2 ** (`CODE_W - 1) - 1;
	localparam int CODE_MIN = -(2 ** (`CODE_W - 1));

	// clamp a shifted accumulator into the code range.
	function automatic code_t sat_code(input acc_t v);
		if (v > CODE_MAX)
			return code_t'(CODE_MAX);
		else if (v < CODE_MIN)
			return code_t'(CODE_MIN);
		return code_t'(v);
	endfunction

endpackage

// ==== hw/ffe_slicer.sv ====
`timescale 1ns/100ps
`include "dsp_config.svh"

module ffe_slicer (
	input  logic                   clk,
	input  logic                   rstb,
	input  dsp_types_pkg::code_t   codes_i [`CHANNEL_WIDTH],
	input  dsp_types_pkg::weight_t weights_i [`FFE_LENGTH],
	input  logic [`SHIFT_W-1:0]    ffe_shift_i,
	input  dsp_types_pkg::code_t   thresh_i,
	output dsp_types_pkg::code_t   estimated_o [`CHANNEL_WIDTH],
	output logic                   bits_o [`CHANNEL_WIDTH]
);
	import dsp_types_pkg::*;

	localparam int CW = `CHANNEL_WIDTH;

	code_t cur_q  [CW];
	code_t prev_q [CW];
	code_t span   [2*CW];
	acc_t  acc    [CW];

	// ******************************
	// input word and its predecessor
	// ******************************

	// symbols before reset count as zero.
	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			cur_q  <= '{default: '0};
			prev_q <= '{default: '0};
		end else begin
			cur_q  <= codes_i;
			prev_q <= cur_q;
		end
	end

	// two words side by side, oldest symbol at index 0.
	always_comb begin
		for (int l = 0; l < CW; l++) begin
			span[l]      = prev_q[l];
			span[CW + l] = cur_q[l];
		end
	end

	// ******************************
	// taps, all lanes in parallel
	// ******************************

	// lanes 0 and 1 reach into the previous word.
	always_comb begin
		for (int l = 0; l < CW; l++) begin
			acc[l] = '0;
			for (int k = 0; k < `FFE_LENGTH; k++)
				acc[l] += weights_i[k] * span[CW + l - k];
		end
	end

	// shift and clamp, then slice the registered value one edge later.
	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			estimated_o <= '{default: '0};
			bits_o      <= '{default: 1'b0};
		end else begin
			for (int l = 0; l < CW; l++) begin
				estimated_o[l] <= sat_code(acc[l] >>> ffe_shift_i);
				bits_o[l]      <= (estimated_o[l] > thresh_i);
			end
		end
	end

endmodule

// ==== hw/mlsd_checker.sv ====
`timescale 1ns/100ps
`include "dsp_config.svh"

module mlsd_checker (
	input  logic                 clk,
	input  logic                 rstb,
	input  logic                 bits_i [`CHANNEL_WIDTH],
	input  dsp_types_pkg::code_t codes_i [`CHANNEL_WIDTH],
	input  dsp_types_pkg::est_t  h0_i,
	input  dsp_types_pkg::est_t  h1_i,
	output logic                 checked_bits_o [`CHANNEL_WIDTH]
);
	import dsp_types_pkg::*;

	localparam int CW = `CHANNEL_WIDTH;

	logic prev_bit_q;
	logic prior  [CW];
	logic decide [CW];
	err_t h0_pos;
	err_t h0_neg;
	err_t h1_pos;
	err_t h1_neg;
	err_t isi    [CW];
	err_t dist0  [CW];
	err_t dist1  [CW];

	function automatic err_t abs_err(input err_t v);
		return (v < 0) ? -v : v;
	endfunction

	// ******************************
	// previous symbol per lane
	// ******************************

	// lane 0 takes the last lane of the word before.
	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb)
			prev_bit_q <= 1'b0;
		else
			prev_bit_q <= bits_i[CW-1];
	end

	always_comb begin
		prior[0] = prev_bit_q;
		for (int l = 1; l < CW; l++)
			prior[l] = bits_i[l-1];
	end

	// ******************************
	// expected codes and decision
	// ******************************

	assign h0_pos = err_t'(h0_i);
	assign h0_neg = -h0_pos;
	assign h1_pos = err_t'(h1_i);
	assign h1_neg = -h1_pos;

	always_comb begin
		for (int l = 0; l < CW; l++) begin
			isi[l]   = prior[l] ? h1_pos : h1_neg;
			dist0[l] = abs_err(err_t'(codes_i[l]) - (isi[l] + h0_neg));
			dist1[l] = abs_err(err_t'(codes_i[l]) - (isi[l] + h0_pos));
			// a tie keeps the slicer decision.
			if (dist1[l] < dist0[l])
				decide[l] = 1'b1;
			else if (dist0[l] < dist1[l])
				decide[l] = 1'b0;
			else
				decide[l] = bits_i[l];
		end
	end

	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb)
			checked_bits_o <= '{default: 1'b0};
		else
			checked_bits_o <= decide;
	end

	// zero estimates leave every symbol tied, so the slicer bit passes through.
	for (genvar g = 0; g < CW; g++) begin : g_zero_est
		zero_est_passes_bits: assert property (@(posedge clk) disable iff (!rstb)
			(h0_i == '0 && h1_i == '0) |=> checked_bits_o[g] == $past(bits_i[g]));
	end

endmodule

// ==== include/dsp_config.svh ====
`ifndef DSP_CONFIG_SVH
`define DSP_CONFIG_SVH

// lanes per clock.
`define CHANNEL_WIDTH 4

// datapath widths.
`define CODE_W 8
`define WEIGHT_W 8
`define ACC_W 18

// ffe taps and the width of its output shift.
`define FFE_LENGTH 3
`define SHIFT_W 3

// raw code delay in cycles after the sampling edge.
`define CODE_ALIGN_DEPTH 2

// wishbone word address and data.
`define CFG_ADDR_W 2
`define WB_DATA_W 32

`endif
